/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ifu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = Simulation completed successfully

SOURCES = $(shell sed -e '/^+/d' $(FILELIST)) ifu_settings.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* beat_counter.sv */
module beat_counter (
  input  logic clk,
  input  logic rst,
  refill_if.cnt rf
);

  fetch_pkg::ofs_t ofs_q;

  // Beats come back in word order starting at word 0
  always_ff @(posedge clk) begin
    if (rst) begin
      ofs_q <= '0;
    end else if (rf.start) begin
      ofs_q <= '0;
    end else if (rf.beat) begin
      ofs_q <= ofs_q + 1'b1; // Wraps to 0 after the last word
    end
  end

  assign rf.ofs = ofs_q;
  assign rf.last = &ofs_q; // Final word of the line

endmodule

/* fetch_ctrl.sv */
`include "ifu_settings.svh"

module fetch_ctrl (
  input  logic clk,
  input  logic rst,
  refill_if.ctrl rf,
  output fetch_pkg::idx_t rd_idx_o,
  output fetch_pkg::ofs_t rd_ofs_o,
  input  fetch_pkg::inst_t inst_i,
  input  fetch_pkg::tag_t tag_i,
  input  logic busy_i,
  output logic miss_o,
  output fetch_pkg::addr_t miss_pc_o,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  output logic valid_o,
  input  logic ready_i,
  input  logic redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic resume_i
);

  fetch_pkg::addr_t pc_q;
  logic stalled_q;
  logic [fetch_pkg::LINES-1:0] line_valid_q;
  logic hit;
  logic accept;
  rv_pkg::inst_class_e inst_class;

  function automatic rv_pkg::inst_class_e classify(fetch_pkg::inst_t w);
    if (w == rv_pkg::FENCE_I) begin
      return rv_pkg::CLS_FENCE;
    end
    case (w[6:0])
      rv_pkg::JAL, rv_pkg::JALR, rv_pkg::BRANCH, rv_pkg::SYSTEM: return rv_pkg::CLS_CTRL;
      default: return rv_pkg::CLS_SEQ;
    endcase
  endfunction

  assign rd_idx_o = fetch_pkg::addr_idx(pc_q);
  assign rd_ofs_o = fetch_pkg::addr_ofs(pc_q);

  // Tags are kept per word, so the word's own tag is compared
  assign hit = line_valid_q[rd_idx_o] && (tag_i == fetch_pkg::addr_tag(pc_q));

  assign valid_o = hit && !stalled_q;
  assign accept = valid_o && ready_i;
  assign inst_class = classify(inst_i);

  assign miss_o = !hit && !stalled_q && !busy_i;
  assign miss_pc_o = pc_q;
  assign inst_o = inst_i;
  assign pc_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `IFU_PC_INIT;
      stalled_q <= 1'b0;
      line_valid_q <= '0;
    end else begin
      if (stalled_q) begin
        // Execute resolves the control instruction
        if (redirect_i) begin
          pc_q <= redirect_pc_i;
          stalled_q <= 1'b0;
        end else if (resume_i) begin
          pc_q <= pc_q + 32'd4;
          stalled_q <= 1'b0;
        end
      end else if (accept) begin
        if (inst_class == rv_pkg::CLS_CTRL) begin
          stalled_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end

      // A flush overrides a line that completes in the same cycle
      if (accept && inst_class == rv_pkg::CLS_FENCE) begin
        line_valid_q <= '0;
      end else if (miss_o) begin
        line_valid_q[rd_idx_o] <= 1'b0; // Line is about to be replaced
      end else if (rf.done) begin
        line_valid_q[rf.fill_idx] <= 1'b1;
      end
    end
  end

endmodule

/* fetch_pkg.sv */
`include "ifu_settings.svh"

package fetch_pkg;

  localparam int LINES = 2 ** `IFU_IDX_BITS;
  localparam int WORDS = 2 ** `IFU_OFS_BITS;
  localparam int LINE_LSB = `IFU_OFS_BITS + 2; // Word offset plus byte bits
  localparam int TAG_W = `IFU_ADDR_W - `IFU_IDX_BITS - LINE_LSB;

  typedef logic [`IFU_ADDR_W-1:0] addr_t;
  typedef logic [`IFU_ADDR_W-1:0] inst_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [`IFU_IDX_BITS-1:0] idx_t;
  typedef logic [`IFU_OFS_BITS-1:0] ofs_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_FILL,
    ST_DONE
  } refill_state_e;

  function automatic tag_t addr_tag(addr_t a);
    return a[`IFU_ADDR_W-1 -: TAG_W];
  endfunction

  function automatic idx_t addr_idx(addr_t a);
    return a[LINE_LSB +: `IFU_IDX_BITS];
  endfunction

  function automatic ofs_t addr_ofs(addr_t a);
    return a[2 +: `IFU_OFS_BITS];
  endfunction

  // Rebuild the aligned base address of a line
  function automatic addr_t line_addr(tag_t t, idx_t i);
    return {t, i, {LINE_LSB{1'b0}}};
  endfunction

endpackage

/* ifu_chk.sv */
`include "ifu_settings.svh"

module ifu_chk (
  input logic clk,
  input logic rst,
  input fetch_pkg::addr_t araddr_o,
  input logic arvalid_o,
  input fetch_pkg::inst_t inst_o,
  input fetch_pkg::addr_t pc_o,
  input logic valid_o,
  input logic ready_i,
  input logic redirect_i,
  input fetch_pkg::addr_t redirect_pc_i,
  input logic resume_i
);

  int unsigned err_cnt = 0; // Watched by the testbench

  logic accept;
  logic ctrl_wait;  // Control instruction handed out, execute not yet resolved
  logic fence_pend; // FENCE.I accepted, no line request seen since
  logic held;
  fetch_pkg::addr_t exp_pc;
  fetch_pkg::addr_t hold_pc;
  fetch_pkg::inst_t hold_inst;

  function automatic logic is_ctrl(fetch_pkg::inst_t w);
    return w[6:0] inside {rv_pkg::JAL, rv_pkg::JALR, rv_pkg::BRANCH, rv_pkg::SYSTEM};
  endfunction

  task automatic report_failure(input string msg);
    err_cnt++;
    $error("%s", msg);
  endtask

  assign accept = valid_o && ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      exp_pc <= `IFU_PC_INIT;
      ctrl_wait <= 1'b0;
      fence_pend <= 1'b0;
      held <= 1'b0;
    end else begin
      if (accept) begin
        exp_pc <= pc_o + 32'd4; // Also the resume target
        ctrl_wait <= is_ctrl(inst_o);
      end else if (ctrl_wait && redirect_i) begin
        exp_pc <= redirect_pc_i;
        ctrl_wait <= 1'b0;
      end else if (ctrl_wait && resume_i) begin
        ctrl_wait <= 1'b0;
      end
      if (accept && inst_o == rv_pkg::FENCE_I) begin
        fence_pend <= 1'b1;
      end else if (arvalid_o) begin
        fence_pend <= 1'b0;
      end
      held <= valid_o && !ready_i;
      hold_pc <= pc_o;
      hold_inst <= inst_o;
    end
  end

  a_req_once: assert property (@(posedge clk) disable iff (rst) arvalid_o |=> !arvalid_o)
    else report_failure("arvalid_o stayed high for two cycles in a row");
  a_req_align: assert property (@(posedge clk) disable iff (rst)
    arvalid_o |-> araddr_o[2:0] == 3'b000)
    else report_failure($sformatf("Mismatch at %0t: araddr_o[2:0] expected 0 got %0h",
                                  $time, araddr_o[2:0]));
  // Memory words carry their own address, except the FENCE.I word
  a_inst_addr: assert property (@(posedge clk) disable iff (rst)
    accept && inst_o != rv_pkg::FENCE_I |-> inst_o[31:7] == pc_o[26:2])
    else report_failure($sformatf("Mismatch at %0t: inst_o[31:7] expected %h got %h",
                                  $time, pc_o[26:2], inst_o[31:7]));
  a_next_pc: assert property (@(posedge clk) disable iff (rst) accept |-> pc_o == exp_pc)
    else report_failure($sformatf("Mismatch at %0t: pc_o expected %h got %h",
                                  $time, exp_pc, pc_o));
  a_stall: assert property (@(posedge clk) disable iff (rst) ctrl_wait |-> !valid_o)
    else report_failure("valid_o rose before execute resolved a control instruction");
  a_hold_pc: assert property (@(posedge clk) disable iff (rst) held |-> pc_o == hold_pc)
    else report_failure($sformatf("Mismatch at %0t: pc_o expected %h got %h",
                                  $time, hold_pc, pc_o));
  a_hold_inst: assert property (@(posedge clk) disable iff (rst) held |-> inst_o == hold_inst)
    else report_failure($sformatf("Mismatch at %0t: inst_o expected %h got %h",
                                  $time, hold_inst, inst_o));
  a_fence: assert property (@(posedge clk) disable iff (rst) fence_pend |-> !valid_o)
    else report_failure("instruction delivered after FENCE.I without a new line request");

endmodule

bind ifu_top ifu_chk u_chk (.*);

/* ifu_settings.svh */
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// Address and data path width
`define IFU_ADDR_W 32

// Cache geometry: 4 lines of 2 words each
`define IFU_IDX_BITS 2
`define IFU_OFS_BITS 1

// First fetch address out of reset
`define IFU_PC_INIT 32'h8000_0000

`endif

/* ifu_tb.sv */
`include "ifu_settings.svh"

module ifu_tb;

  localparam int N_ACCEPT = 400;
  localparam int CYCLES_PER_INST = 40; // Worst case miss, burst latency and stall
  localparam int CLK_PERIOD = 8;

  logic clk = 1'b0;
  logic rst;
  fetch_pkg::addr_t araddr_o;
  logic arvalid_o;
  fetch_pkg::inst_t rdata_i;
  logic rvalid_i;
  fetch_pkg::inst_t inst_o;
  fetch_pkg::addr_t pc_o;
  logic valid_o;
  logic ready_i;
  logic redirect_i;
  fetch_pkg::addr_t redirect_pc_i;
  logic resume_i;

  logic [31:0] rng = 32'h6cbd;
  int n_accept = 0;
  int resolve_wait = 0; // Cycles until execute answers a control instruction
  fetch_pkg::addr_t mem_base = '0;
  int mem_lat = 0;
  int beat_no = 0;
  logic mem_busy = 1'b0;

  ifu_top DUT (
    .clk           (clk),
    .rst           (rst),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .resume_i      (resume_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each word encodes its own address, opcode picked by position
  function automatic fetch_pkg::inst_t mem_word(fetch_pkg::addr_t a);
    if (a == 32'h8000_0040) begin
      return rv_pkg::FENCE_I;
    end
    if (a[5:2] == 4'b0111) begin
      return {a[26:2], rv_pkg::BRANCH};
    end
    return {a[26:2], rv_pkg::OP_IMM};
  endfunction

  function automatic logic needs_resolve(fetch_pkg::inst_t w);
    return w[6:0] inside {rv_pkg::JAL, rv_pkg::JALR, rv_pkg::BRANCH, rv_pkg::SYSTEM};
  endfunction

  initial begin
    rst <= 1'b1;
    rdata_i <= '0;
    rvalid_i <= 1'b0;
    ready_i <= 1'b0;
    redirect_i <= 1'b0;
    redirect_pc_i <= '0;
    resume_i <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  always @(posedge clk) begin
    if (!rst) begin
      rng = xorshift32(rng);

      // Execute stage
      redirect_i <= 1'b0;
      resume_i <= 1'b0;
      if (valid_o && ready_i) begin
        n_accept = n_accept + 1;
        if (needs_resolve(inst_o)) begin
          resolve_wait = 1 + int'(rng[5:4]);
        end
      end else if (resolve_wait > 0) begin
        resolve_wait = resolve_wait - 1;
        if (resolve_wait == 0) begin
          if (rng[12]) begin
            redirect_i <= 1'b1;
            redirect_pc_i <= `IFU_PC_INIT; // Loop back to the base
          end else begin
            resume_i <= 1'b1;
          end
        end
      end

      // Memory model, one burst of 2 beats per request
      rvalid_i <= 1'b0;
      if (arvalid_o) begin
        mem_base = araddr_o;
        mem_lat = 1 + int'(rng[9:8]);
        beat_no = 0;
        mem_busy = 1'b1;
      end
      if (mem_busy) begin
        if (mem_lat > 1) begin
          mem_lat = mem_lat - 1;
        end else begin
          rvalid_i <= 1'b1;
          rdata_i <= mem_word(mem_base + 32'(beat_no * 4));
          beat_no = beat_no + 1;
          mem_busy = (beat_no < fetch_pkg::WORDS);
        end
      end

      // Downstream holds off while a line is still arriving
      ready_i <= !mem_busy && (rng[1:0] != 2'b00);
    end
  end

  always @(negedge clk) begin
    if (DUT.u_chk.err_cnt != 0) begin
      $display("Simulation failed");
      $fatal(1, "A checker assertion failed");
    end
  end

  initial begin
    wait (n_accept >= N_ACCEPT);
    repeat (4) @(posedge clk);
    if (DUT.u_chk.err_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Checker reported %0d failures", DUT.u_chk.err_cnt);
    end
  end

  // Watchdog
  initial begin
    #(N_ACCEPT * CYCLES_PER_INST * CLK_PERIOD);
    $display("Simulation failed");
    $fatal(1, "Timeout with only %0d of %0d instructions accepted", n_accept, N_ACCEPT);
  end

endmodule

/* ifu_top.sv */
module ifu_top (
  input  logic clk,
  input  logic rst,
  // Read bus
  output fetch_pkg::addr_t araddr_o,
  output logic arvalid_o,
  input  fetch_pkg::inst_t rdata_i,
  input  logic rvalid_i,
  // Downstream
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  output logic valid_o,
  input  logic ready_i,
  // Execute stage
  input  logic redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic resume_i
);

  refill_if rf ();

  fetch_pkg::idx_t rd_idx;
  fetch_pkg::ofs_t rd_ofs;
  fetch_pkg::inst_t rd_inst;
  fetch_pkg::tag_t rd_tag;
  fetch_pkg::addr_t miss_pc;
  logic miss;
  logic busy;

  assign rf.beat = rvalid_i; // Each bus beat is one word of the line

  refill_fsm u_refill_fsm (
    .clk       (clk),
    .rst       (rst),
    .miss_i    (miss),
    .miss_pc_i (miss_pc),
    .busy_o    (busy),
    .arvalid_o (arvalid_o),
    .araddr_o  (araddr_o),
    .rf        (rf.fsm)
  );

  beat_counter u_beat_counter (
    .clk (clk),
    .rst (rst),
    .rf  (rf.cnt)
  );

  line_store #(.T(fetch_pkg::inst_t)) data_store (
    .clk       (clk),
    .wr_i      (rf.beat),
    .wr_idx_i  (rf.fill_idx),
    .wr_ofs_i  (rf.ofs),
    .wr_data_i (rdata_i),
    .rd_idx_i  (rd_idx),
    .rd_ofs_i  (rd_ofs),
    .rd_data_o (rd_inst)
  );

  line_store #(.T(fetch_pkg::tag_t)) tag_store (
    .clk       (clk),
    .wr_i      (rf.beat),
    .wr_idx_i  (rf.fill_idx),
    .wr_ofs_i  (rf.ofs),
    .wr_data_i (rf.fill_tag),
    .rd_idx_i  (rd_idx),
    .rd_ofs_i  (rd_ofs),
    .rd_data_o (rd_tag)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .rf            (rf.ctrl),
    .rd_idx_o      (rd_idx),
    .rd_ofs_o      (rd_ofs),
    .inst_i        (rd_inst),
    .tag_i         (rd_tag),
    .busy_i        (busy),
    .miss_o        (miss),
    .miss_pc_o     (miss_pc),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .resume_i      (resume_i)
  );

endmodule

/* line_store.sv */
module line_store #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic wr_i,
  input  fetch_pkg::idx_t wr_idx_i,
  input  fetch_pkg::ofs_t wr_ofs_i,
  input  T wr_data_i,
  input  fetch_pkg::idx_t rd_idx_i,
  input  fetch_pkg::ofs_t rd_ofs_i,
  output T rd_data_o
);

  T mem [fetch_pkg::LINES][fetch_pkg::WORDS];

  // One word per returned beat
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_idx_i][wr_ofs_i] <= wr_data_i;
    end
  end

  assign rd_data_o = mem[rd_idx_i][rd_ofs_i]; // Same-cycle lookup

endmodule

/* refill_fsm.sv */
module refill_fsm (
  input  logic clk,
  input  logic rst,
  input  logic miss_i,
  input  fetch_pkg::addr_t miss_pc_i,
  output logic busy_o,
  output logic arvalid_o,
  output fetch_pkg::addr_t araddr_o,
  refill_if.fsm rf
);

  fetch_pkg::refill_state_e state_q;
  fetch_pkg::refill_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::ST_IDLE: begin
        if (miss_i) begin
          state_d = fetch_pkg::ST_REQUEST;
        end
      end
      fetch_pkg::ST_REQUEST: begin
        state_d = fetch_pkg::ST_FILL; // Single-cycle request strobe
      end
      fetch_pkg::ST_FILL: begin
        if (rf.beat && rf.last) begin
          state_d = fetch_pkg::ST_DONE;
        end
      end
      fetch_pkg::ST_DONE: begin
        state_d = fetch_pkg::ST_IDLE;
      end
      default: begin
        state_d = fetch_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Line address is frozen for the whole refill, so a redirect
  // in the middle does not disturb it
  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::ST_IDLE && miss_i) begin
      rf.fill_idx <= fetch_pkg::addr_idx(miss_pc_i);
      rf.fill_tag <= fetch_pkg::addr_tag(miss_pc_i);
    end
  end

  assign arvalid_o = (state_q == fetch_pkg::ST_REQUEST);
  assign araddr_o = fetch_pkg::line_addr(rf.fill_tag, rf.fill_idx);
  assign rf.start = (state_q == fetch_pkg::ST_REQUEST);
  assign rf.done = (state_q == fetch_pkg::ST_DONE);
  assign busy_o = (state_q != fetch_pkg::ST_IDLE); // Blocks a second miss

endmodule

/* refill_if.sv */
interface refill_if;

  logic start;
  logic beat;
  fetch_pkg::ofs_t ofs;
  logic last;
  fetch_pkg::idx_t fill_idx;
  fetch_pkg::tag_t fill_tag;
  logic done;

  modport fsm (
    output start, fill_idx, fill_tag, done,
    input beat, last
  );

  modport cnt (
    input start, beat,
    output ofs, last
  );

  // Write side of the data and tag arrays
  modport store (
    input beat, ofs, fill_idx, fill_tag
  );

  modport ctrl (
    input done, fill_idx
  );

endinterface

/* rv_pkg.sv */
package rv_pkg;

  // Major opcodes, bits 6:0 of the instruction word
  typedef enum logic [6:0] {
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    SYSTEM   = 7'b1110011,
    MISC_MEM = 7'b0001111,
    OP_IMM   = 7'b0010011
  } opcode_e;

  // fence.i: imm 0, rs1 0, funct3 001, rd 0
  localparam logic [31:0] FENCE_I = {12'h000, 5'd0, 3'b001, 5'd0, MISC_MEM};

  // How fetch treats an instruction once it has been handed downstream
  typedef enum logic [1:0] {
    CLS_SEQ,   // Fall through to pc+4
    CLS_CTRL,  // Wait for execute to resolve the target
    CLS_FENCE  // Flush the cache then fall through
  } inst_class_e;

endpackage

/* sim.f */
+incdir+.
fetch_pkg.sv
rv_pkg.sv
refill_if.sv
refill_fsm.sv
beat_counter.sv
line_store.sv
fetch_ctrl.sv
ifu_top.sv
ifu_chk.sv
ifu_tb.sv
